//--- logic/axi_read_arbiter.sv
`timescale 1ns/1ps

module axi_read_arbiter (
    input  logic                   clock,
    input  logic                   reset,
    // m0, instruction bridge
    input  logic                   m0_ar_valid_i,
    output logic                   m0_ar_ready_o,
    input  cache_axi_pkg::axi_ar_t m0_ar_i,
    output logic                   m0_r_valid_o,
    input  logic                   m0_r_ready_i,
    output cache_axi_pkg::axi_r_t  m0_r_o,
    // m1, data bridge
    input  logic                   m1_ar_valid_i,
    output logic                   m1_ar_ready_o,
    input  cache_axi_pkg::axi_ar_t m1_ar_i,
    output logic                   m1_r_valid_o,
    input  logic                   m1_r_ready_i,
    output cache_axi_pkg::axi_r_t  m1_r_o,
    // slave port
    output logic                   s_ar_valid_o,
    input  logic                   s_ar_ready_i,
    output cache_axi_pkg::axi_ar_t s_ar_o,
    input  logic                   s_r_valid_i,
    output logic                   s_r_ready_o,
    input  cache_axi_pkg::axi_r_t  s_r_i
);

    logic busy_q;
    logic owner_q;     // 1 = m1
    logic prio_q;      // who wins a tie
    logic sel;
    logic ar_fire;
    logic r_last_fire;

    always_comb begin
        if (busy_q)
            sel = owner_q;
        else if (m0_ar_valid_i && m1_ar_valid_i)
            sel = prio_q;
        else
            sel = m1_ar_valid_i;
    end

    assign s_ar_valid_o  = !busy_q && (m0_ar_valid_i || m1_ar_valid_i);
    assign s_ar_o        = sel ? m1_ar_i : m0_ar_i;
    assign m0_ar_ready_o = !busy_q && !sel && s_ar_ready_i;
    assign m1_ar_ready_o = !busy_q && sel && s_ar_ready_i;
    assign ar_fire       = s_ar_valid_o && s_ar_ready_i;

    // r beats steered to the owner only
    assign m0_r_valid_o = busy_q && !owner_q && s_r_valid_i;
    assign m1_r_valid_o = busy_q && owner_q && s_r_valid_i;
    assign m0_r_o       = s_r_i;
    assign m1_r_o       = s_r_i;
    assign s_r_ready_o  = busy_q && (owner_q ? m1_r_ready_i : m0_r_ready_i);
    assign r_last_fire  = s_r_valid_i && s_r_ready_o && s_r_i.last;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            busy_q  <= 1'b0;
            owner_q <= 1'b0;
            prio_q  <= 1'b1;    // data bridge first
        end else if (ar_fire) begin
            busy_q  <= 1'b1;
            owner_q <= sel;
            prio_q  <= !sel;
        end else if (r_last_fire) begin
            busy_q  <= 1'b0;
        end
    end

endmodule

//--- logic/axi_sram_slave.sv
`timescale 1ns/1ps

module axi_sram_slave #(
    parameter int ADDR_WIDTH = 32,
    parameter int MEM_WORDS  = 256
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   ar_valid_i,
    output logic                   ar_ready_o,
    input  cache_axi_pkg::axi_ar_t ar_i,
    output logic                   r_valid_o,
    input  logic                   r_ready_i,
    output cache_axi_pkg::axi_r_t  r_o,
    input  logic                   aw_valid_i,
    output logic                   aw_ready_o,
    input  cache_axi_pkg::axi_aw_t aw_i,
    input  logic                   w_valid_i,
    output logic                   w_ready_o,
    input  cache_axi_pkg::axi_w_t  w_i,
    output logic                   b_valid_o,
    input  logic                   b_ready_i,
    output cache_axi_pkg::axi_b_t  b_o
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam logic [ADDR_WIDTH-1:0] BEAT_BYTES = ADDR_WIDTH'(cache_axi_pkg::BEAT_BITS / 8);

    typedef enum logic [1:0] {
        sw_idle,
        sw_data,
        sw_resp
    } wr_state_t;

    cache_axi_pkg::beat_t mem [MEM_WORDS];

    logic                  rd_active_q;
    logic [ADDR_WIDTH-1:0] rd_addr_q;
    logic [7:0]            rd_cnt_q;     // beats left after this one
    wr_state_t             wr_state_q;
    logic [ADDR_WIDTH-1:0] wr_addr_q;
    logic [7:0]            wr_cnt_q;
    logic                  wr_id_q;
    logic                  r_fire;
    logic                  w_fire;

    function automatic logic [IDX_W-1:0] word_index(input logic [ADDR_WIDTH-1:0] addr);
        return IDX_W'((addr / BEAT_BYTES) % MEM_WORDS);
    endfunction

    // read burst
    assign ar_ready_o = !rd_active_q;
    assign r_valid_o  = rd_active_q;
    assign r_o.data   = mem[word_index(rd_addr_q)];
    assign r_o.last   = (rd_cnt_q == 8'd0);
    assign r_o.resp   = 2'b00;                   // always okay
    assign r_fire     = r_valid_o && r_ready_i;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            rd_active_q <= 1'b0;
            rd_addr_q   <= '0;
            rd_cnt_q    <= '0;
        end else if (ar_valid_i && ar_ready_o) begin
            rd_active_q <= 1'b1;
            rd_addr_q   <= ar_i.addr[ADDR_WIDTH-1:0];
            rd_cnt_q    <= ar_i.len;
        end else if (r_fire) begin
            if (r_o.last)
                rd_active_q <= 1'b0;
            rd_addr_q <= rd_addr_q + BEAT_BYTES;
            rd_cnt_q  <= rd_cnt_q - 8'd1;
        end
    end

    // write burst
    assign aw_ready_o = (wr_state_q == sw_idle);
    assign w_ready_o  = (wr_state_q == sw_data);
    assign b_valid_o  = (wr_state_q == sw_resp);
    assign b_o        = '{id: wr_id_q, resp: 2'b00};
    assign w_fire     = w_valid_i && w_ready_o;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_state_q <= sw_idle;
            wr_addr_q  <= '0;
            wr_cnt_q   <= '0;
            wr_id_q    <= 1'b0;
        end else begin
            case (wr_state_q)
                sw_idle: begin
                    if (aw_valid_i) begin
                        wr_state_q <= sw_data;
                        wr_addr_q  <= aw_i.addr[ADDR_WIDTH-1:0];
                        wr_cnt_q   <= aw_i.len;
                        wr_id_q    <= aw_i.id;   // echoed on b
                    end
                end
                sw_data: begin
                    if (w_fire) begin
                        wr_addr_q <= wr_addr_q + BEAT_BYTES;
                        wr_cnt_q  <= wr_cnt_q - 8'd1;
                        if (wr_cnt_q == 8'd0)
                            wr_state_q <= sw_resp;
                    end
                end
                sw_resp: if (b_ready_i) wr_state_q <= sw_idle;
                default: wr_state_q <= sw_idle;
            endcase
        end
    end

    // byte lanes by strobe
    always_ff @(posedge clock) begin
        if (w_fire) begin
            for (int b = 0; b < 8; b++) begin
                if (w_i.strb[b])
                    mem[word_index(wr_addr_q)][b*8 +: 8] <= w_i.data[b*8 +: 8];
            end
        end
    end

endmodule

//--- logic/cache_axi_pkg.sv
package cache_axi_pkg;

    localparam int BEAT_BITS      = 64;
    localparam int BEATS_PER_LINE = 4;
    localparam int LINE_BITS      = BEAT_BITS * BEATS_PER_LINE;

    // fixed burst shape, one line per burst
    localparam logic [7:0] BURST_LEN  = 8'd3;
    localparam logic [2:0] BURST_SIZE = 3'd3;    // 8-byte beats

    localparam logic ICACHE_ID = 1'b0;
    localparam logic DCACHE_ID = 1'b1;

    typedef logic [BEAT_BITS-1:0]   beat_t;
    typedef logic [LINE_BITS-1:0]   line_t;      // beat k at bits 64k and up
    typedef logic [LINE_BITS/8-1:0] line_mask_t;
    typedef logic [31:0]            addr_t;

    typedef struct packed {
        addr_t      addr;
        logic       id;
        logic [7:0] len;
        logic [2:0] size;
    } axi_ar_t;

    typedef struct packed {
        addr_t      addr;
        logic       id;
        logic [7:0] len;
        logic [2:0] size;
    } axi_aw_t;

    typedef struct packed {
        beat_t      data;
        logic       last;
        logic [1:0] resp;
    } axi_r_t;

    typedef struct packed {
        beat_t      data;
        logic [7:0] strb;
        logic       last;
    } axi_w_t;

    typedef struct packed {
        logic       id;
        logic [1:0] resp;
    } axi_b_t;

endpackage

//--- logic/cache_mem_subsystem.sv
`timescale 1ns/1ps

module cache_mem_subsystem #(
    parameter int ADDR_WIDTH = 32,
    parameter int MEM_WORDS  = 256
) (
    input  logic                      clock,
    input  logic                      reset,
    // data cache
    input  logic                      dc_rd_req_valid_i,
    output logic                      dc_rd_req_ready_o,
    input  cache_axi_pkg::addr_t      dc_rd_addr_i,
    output logic                      dc_rd_beat_valid_o,
    output cache_axi_pkg::beat_t      dc_rd_beat_o,
    output logic                      dc_rd_last_o,
    input  logic                      dc_wr_req_valid_i,
    output logic                      dc_wr_req_ready_o,
    input  cache_axi_pkg::addr_t      dc_wr_addr_i,
    input  cache_axi_pkg::line_t      dc_wr_line_i,
    input  cache_axi_pkg::line_mask_t dc_wr_mask_i,
    output logic                      dc_wr_done_o,
    // instruction cache
    input  logic                      ic_fetch_valid_i,
    output logic                      ic_fetch_ready_o,
    input  cache_axi_pkg::addr_t      ic_fetch_addr_i,
    output logic                      ic_line_valid_o,
    output cache_axi_pkg::line_t      ic_line_o
);

    logic m0_ar_valid, m0_ar_ready, m0_r_valid, m0_r_ready;
    logic m1_ar_valid, m1_ar_ready, m1_r_valid, m1_r_ready;
    logic s_ar_valid, s_ar_ready, s_r_valid, s_r_ready;
    logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    cache_axi_pkg::axi_ar_t m0_ar, m1_ar, s_ar;
    cache_axi_pkg::axi_r_t  m0_r, m1_r, s_r;
    cache_axi_pkg::axi_aw_t aw;
    cache_axi_pkg::axi_w_t  w;
    cache_axi_pkg::axi_b_t  b;

    dcache_axi_bridge dcache_axi_bridge_i (
        .clock, .reset,
        .rd_req_valid_i(dc_rd_req_valid_i), .rd_req_ready_o(dc_rd_req_ready_o),
        .rd_addr_i(dc_rd_addr_i), .rd_beat_valid_o(dc_rd_beat_valid_o),
        .rd_beat_o(dc_rd_beat_o), .rd_last_o(dc_rd_last_o),
        .wr_req_valid_i(dc_wr_req_valid_i), .wr_req_ready_o(dc_wr_req_ready_o),
        .wr_addr_i(dc_wr_addr_i), .wr_line_i(dc_wr_line_i),
        .wr_mask_i(dc_wr_mask_i), .wr_done_o(dc_wr_done_o),
        .ar_valid_o(m1_ar_valid), .ar_ready_i(m1_ar_ready), .ar_o(m1_ar),
        .r_valid_i(m1_r_valid), .r_ready_o(m1_r_ready), .r_i(m1_r),
        .aw_valid_o(aw_valid), .aw_ready_i(aw_ready), .aw_o(aw),
        .w_valid_o(w_valid), .w_ready_i(w_ready), .w_o(w),
        .b_valid_i(b_valid), .b_ready_o(b_ready), .b_i(b)
    );

    icache_axi_bridge icache_axi_bridge_i (
        .clock, .reset,
        .fetch_valid_i(ic_fetch_valid_i), .fetch_ready_o(ic_fetch_ready_o),
        .fetch_addr_i(ic_fetch_addr_i),
        .line_valid_o(ic_line_valid_o), .line_o(ic_line_o),
        .ar_valid_o(m0_ar_valid), .ar_ready_i(m0_ar_ready), .ar_o(m0_ar),
        .r_valid_i(m0_r_valid), .r_ready_o(m0_r_ready), .r_i(m0_r)
    );

    axi_read_arbiter axi_read_arbiter_i (
        .clock, .reset,
        .m0_ar_valid_i(m0_ar_valid), .m0_ar_ready_o(m0_ar_ready), .m0_ar_i(m0_ar),
        .m0_r_valid_o(m0_r_valid), .m0_r_ready_i(m0_r_ready), .m0_r_o(m0_r),
        .m1_ar_valid_i(m1_ar_valid), .m1_ar_ready_o(m1_ar_ready), .m1_ar_i(m1_ar),
        .m1_r_valid_o(m1_r_valid), .m1_r_ready_i(m1_r_ready), .m1_r_o(m1_r),
        .s_ar_valid_o(s_ar_valid), .s_ar_ready_i(s_ar_ready), .s_ar_o(s_ar),
        .s_r_valid_i(s_r_valid), .s_r_ready_o(s_r_ready), .s_r_i(s_r)
    );

    // single writer, so aw/w/b skip the arbiter
    axi_sram_slave #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .MEM_WORDS (MEM_WORDS)
    ) axi_sram_slave_i (
        .clock, .reset,
        .ar_valid_i(s_ar_valid), .ar_ready_o(s_ar_ready), .ar_i(s_ar),
        .r_valid_o(s_r_valid), .r_ready_i(s_r_ready), .r_o(s_r),
        .aw_valid_i(aw_valid), .aw_ready_o(aw_ready), .aw_i(aw),
        .w_valid_i(w_valid), .w_ready_o(w_ready), .w_i(w),
        .b_valid_o(b_valid), .b_ready_i(b_ready), .b_o(b)
    );

endmodule

//--- logic/dcache_axi_bridge.sv
`timescale 1ns/1ps

module dcache_axi_bridge (
    input  logic                    clock,
    input  logic                    reset,
    // line read
    input  logic                    rd_req_valid_i,
    output logic                    rd_req_ready_o,
    input  cache_axi_pkg::addr_t    rd_addr_i,
    output logic                    rd_beat_valid_o,
    output cache_axi_pkg::beat_t    rd_beat_o,
    output logic                    rd_last_o,
    // line write
    input  logic                    wr_req_valid_i,
    output logic                    wr_req_ready_o,
    input  cache_axi_pkg::addr_t    wr_addr_i,
    input  cache_axi_pkg::line_t    wr_line_i,
    input  cache_axi_pkg::line_mask_t wr_mask_i,
    output logic                    wr_done_o,
    // axi master
    output logic                    ar_valid_o,
    input  logic                    ar_ready_i,
    output cache_axi_pkg::axi_ar_t  ar_o,
    input  logic                    r_valid_i,
    output logic                    r_ready_o,
    input  cache_axi_pkg::axi_r_t   r_i,
    output logic                    aw_valid_o,
    input  logic                    aw_ready_i,
    output cache_axi_pkg::axi_aw_t  aw_o,
    output logic                    w_valid_o,
    input  logic                    w_ready_i,
    output cache_axi_pkg::axi_w_t   w_o,
    input  logic                    b_valid_i,
    output logic                    b_ready_o,
    input  cache_axi_pkg::axi_b_t   b_i
);

    typedef enum logic [1:0] {
        r_idle,
        r_addr_wait,
        r_data_wait
    } rd_state_t;

    typedef enum logic [1:0] {
        w_idle,
        w_addr_wait,
        w_data_wait,
        w_resp_wait
    } wr_state_t;

    localparam cache_axi_pkg::addr_t LINE_OFFSET_MASK = cache_axi_pkg::addr_t'(
        cache_axi_pkg::LINE_BITS / 8 - 1);

    rd_state_t rd_state_q;
    wr_state_t wr_state_q;
    cache_axi_pkg::addr_t rd_addr_q;
    cache_axi_pkg::addr_t wr_addr_q;
    cache_axi_pkg::line_t wr_line_q;
    cache_axi_pkg::line_mask_t wr_mask_q;
    logic [1:0] beat_cnt_q;
    logic w_last;

    // read side
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            rd_state_q <= r_idle;
        end else begin
            case (rd_state_q)
                r_idle:      if (rd_req_valid_i) rd_state_q <= r_addr_wait;
                r_addr_wait: if (ar_ready_i) rd_state_q <= r_data_wait;
                r_data_wait: if (r_valid_i && r_i.last) rd_state_q <= r_idle;
                default:     rd_state_q <= r_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rd_req_valid_i && rd_req_ready_o)
            rd_addr_q <= rd_addr_i & ~LINE_OFFSET_MASK;  // line aligned
    end

    assign rd_req_ready_o  = (rd_state_q == r_idle);
    assign ar_valid_o      = (rd_state_q == r_addr_wait);
    assign ar_o            = '{addr: rd_addr_q, id: cache_axi_pkg::DCACHE_ID,
                               len: cache_axi_pkg::BURST_LEN,
                               size: cache_axi_pkg::BURST_SIZE};
    assign r_ready_o       = 1'b1;
    assign rd_beat_valid_o = r_valid_i && (rd_state_q == r_data_wait);  // beats pass straight through
    assign rd_beat_o       = r_i.data;
    assign rd_last_o       = rd_beat_valid_o && r_i.last;

    // write side
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_state_q <= w_idle;
            beat_cnt_q <= '0;
        end else begin
            case (wr_state_q)
                w_idle: begin
                    beat_cnt_q <= '0;
                    if (wr_req_valid_i) wr_state_q <= w_addr_wait;
                end
                w_addr_wait: if (aw_ready_i) wr_state_q <= w_data_wait;
                w_data_wait: begin
                    if (w_ready_i) begin
                        beat_cnt_q <= beat_cnt_q + 2'd1;
                        if (w_last) wr_state_q <= w_resp_wait;
                    end
                end
                w_resp_wait: begin
                    if (b_valid_i && b_i.id == cache_axi_pkg::DCACHE_ID)
                        wr_state_q <= w_idle;
                end
                default: wr_state_q <= w_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (wr_req_valid_i && wr_req_ready_o) begin
            wr_addr_q <= wr_addr_i & ~LINE_OFFSET_MASK;
            wr_line_q <= wr_line_i;
            wr_mask_q <= wr_mask_i;
        end
    end

    assign w_last = (beat_cnt_q == 2'(cache_axi_pkg::BEATS_PER_LINE - 1));

    assign wr_req_ready_o = (wr_state_q == w_idle);
    assign aw_valid_o     = (wr_state_q == w_addr_wait);
    assign aw_o           = '{addr: wr_addr_q, id: cache_axi_pkg::DCACHE_ID,
                              len: cache_axi_pkg::BURST_LEN,
                              size: cache_axi_pkg::BURST_SIZE};
    assign w_valid_o      = (wr_state_q == w_data_wait);
    assign w_o.data       = wr_line_q[beat_cnt_q*cache_axi_pkg::BEAT_BITS +: cache_axi_pkg::BEAT_BITS];
    assign w_o.strb       = wr_mask_q[beat_cnt_q*8 +: 8];  // byte group k
    assign w_o.last       = w_last;
    assign b_ready_o      = 1'b1;
    assign wr_done_o      = b_valid_i && (wr_state_q == w_resp_wait)
                            && (b_i.id == cache_axi_pkg::DCACHE_ID);

endmodule

//--- logic/icache_axi_bridge.sv
`timescale 1ns/1ps

module icache_axi_bridge (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   fetch_valid_i,
    output logic                   fetch_ready_o,
    input  cache_axi_pkg::addr_t   fetch_addr_i,
    output logic                   line_valid_o,
    output cache_axi_pkg::line_t   line_o,
    output logic                   ar_valid_o,
    input  logic                   ar_ready_i,
    output cache_axi_pkg::axi_ar_t ar_o,
    input  logic                   r_valid_i,
    output logic                   r_ready_o,
    input  cache_axi_pkg::axi_r_t  r_i
);

    typedef enum logic [1:0] {
        f_idle,
        f_addr_wait,
        f_data_wait,
        f_line_out
    } fetch_state_t;

    fetch_state_t state_q;
    cache_axi_pkg::addr_t addr_q;
    cache_axi_pkg::line_t line_q;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= f_idle;
        end else begin
            case (state_q)
                f_idle:      if (fetch_valid_i) state_q <= f_addr_wait;
                f_addr_wait: if (ar_ready_i) state_q <= f_data_wait;
                f_data_wait: if (r_valid_i && r_i.last) state_q <= f_line_out;
                f_line_out:  state_q <= f_idle;    // one cycle of line_valid
                default:     state_q <= f_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_valid_i && fetch_ready_o)
            addr_q <= {fetch_addr_i[31:5], 5'b0};
        // shift in from the top so beat 0 ends in the low bits
        if (r_valid_i && state_q == f_data_wait)
            line_q <= {r_i.data, line_q[cache_axi_pkg::LINE_BITS-1:cache_axi_pkg::BEAT_BITS]};
    end

    assign fetch_ready_o = (state_q == f_idle);
    assign ar_valid_o    = (state_q == f_addr_wait);
    assign ar_o          = '{addr: addr_q, id: cache_axi_pkg::ICACHE_ID,
                             len: cache_axi_pkg::BURST_LEN,
                             size: cache_axi_pkg::BURST_SIZE};
    assign r_ready_o     = 1'b1;
    assign line_valid_o  = (state_q == f_line_out);
    assign line_o        = line_q;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the cache memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module cache_mem_subsystem_tb -o cache_mem_subsystem_tb \
    || { echo "build failed"; exit 1; }

run_out=$(./obj_dir/cache_mem_subsystem_tb 2>&1)
printf '%s\n' "$run_out"

printf '%s\n' "$run_out" | grep -qx "Simulation completed successfully" && exit 0 || exit 1

//--- sim.f
logic/cache_axi_pkg.sv
logic/dcache_axi_bridge.sv
logic/icache_axi_bridge.sv
logic/axi_read_arbiter.sv
logic/axi_sram_slave.sv
logic/cache_mem_subsystem.sv
testbench/cache_mem_subsystem_tb.sv

//--- testbench/cache_mem_subsystem_tb.sv
`timescale 1ns/1ps

module cache_mem_subsystem_tb;

    localparam int MEM_WORDS  = 256;
    localparam int LINES      = MEM_WORDS / cache_axi_pkg::BEATS_PER_LINE;
    localparam int RAND_OPS   = 40;
    localparam int MAX_CYCLES = 4000;    // whole run is roughly 900 cycles

    logic clock;
    logic reset;
    logic dc_rd_req_valid;
    logic dc_rd_req_ready;
    cache_axi_pkg::addr_t dc_rd_addr;
    logic dc_rd_beat_valid;
    cache_axi_pkg::beat_t dc_rd_beat;
    logic dc_rd_last;
    logic dc_wr_req_valid;
    logic dc_wr_req_ready;
    cache_axi_pkg::addr_t dc_wr_addr;
    cache_axi_pkg::line_t dc_wr_line;
    cache_axi_pkg::line_mask_t dc_wr_mask;
    logic dc_wr_done;
    logic ic_fetch_valid;
    logic ic_fetch_ready;
    cache_axi_pkg::addr_t ic_fetch_addr;
    logic ic_line_valid;
    cache_axi_pkg::line_t ic_line;

    cache_axi_pkg::beat_t ref_mem [MEM_WORDS];   // memory as the testbench predicts it
    cache_axi_pkg::line_t exp_dc_line;
    cache_axi_pkg::line_t exp_ic_line;
    cache_axi_pkg::beat_t exp_dc_beat;
    cache_axi_pkg::addr_t wr_cur_addr;
    cache_axi_pkg::line_t wr_cur_line;
    cache_axi_pkg::line_mask_t wr_cur_mask;
    logic [1:0] beat_idx;
    logic [15:0] lfsr;
    int rd_issued;
    int rd_done_cnt;
    int fetch_issued;
    int fetch_done_cnt;
    int wr_issued;
    int wr_done_cnt;
    int cycle_cnt;
    int error_count;
    int test_errors;
    int pass_count;
    int fail_count;

    cache_mem_subsystem #(
        .ADDR_WIDTH(32),
        .MEM_WORDS (MEM_WORDS)
    ) cache_mem_subsystem_i (
        .clock(clock),
        .reset(reset),
        .dc_rd_req_valid_i(dc_rd_req_valid),
        .dc_rd_req_ready_o(dc_rd_req_ready),
        .dc_rd_addr_i(dc_rd_addr),
        .dc_rd_beat_valid_o(dc_rd_beat_valid),
        .dc_rd_beat_o(dc_rd_beat),
        .dc_rd_last_o(dc_rd_last),
        .dc_wr_req_valid_i(dc_wr_req_valid),
        .dc_wr_req_ready_o(dc_wr_req_ready),
        .dc_wr_addr_i(dc_wr_addr),
        .dc_wr_line_i(dc_wr_line),
        .dc_wr_mask_i(dc_wr_mask),
        .dc_wr_done_o(dc_wr_done),
        .ic_fetch_valid_i(ic_fetch_valid),
        .ic_fetch_ready_o(ic_fetch_ready),
        .ic_fetch_addr_i(ic_fetch_addr),
        .ic_line_valid_o(ic_line_valid),
        .ic_line_o(ic_line)
    );

    always #5 clock = ~clock;

    // fibonacci lfsr, taps 16 14 13 11, one step per bit taken
    function automatic logic [255:0] take_bits(input int n);
        logic [255:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v = {v[254:0], fb};
        end
        return v;
    endfunction

    // first beat of the line, word index is address / 8 modulo memory size
    function automatic int line_base(input cache_axi_pkg::addr_t addr);
        return int'((addr / 8) % MEM_WORDS) & ~(cache_axi_pkg::BEATS_PER_LINE - 1);
    endfunction

    function automatic cache_axi_pkg::line_t ref_line(input cache_axi_pkg::addr_t addr);
        cache_axi_pkg::line_t l;
        int base;
        base = line_base(addr);
        for (int k = 0; k < cache_axi_pkg::BEATS_PER_LINE; k++)
            l[k*64 +: 64] = ref_mem[base + k];
        return l;
    endfunction

    function automatic cache_axi_pkg::line_t merge_line(input cache_axi_pkg::line_t old_line,
                                                        input cache_axi_pkg::line_t new_line,
                                                        input cache_axi_pkg::line_mask_t mask);
        cache_axi_pkg::line_t l;
        l = old_line;
        for (int b = 0; b < 32; b++)
            if (mask[b]) l[b*8 +: 8] = new_line[b*8 +: 8];
        return l;
    endfunction

    // preload value, built from the whole byte address
    function automatic cache_axi_pkg::beat_t fill_beat(input int word);
        logic [31:0] byte_addr;
        byte_addr = 32'(word * 8);
        return {byte_addr ^ 32'hA5A5_0000, ~byte_addr};
    endfunction

    function automatic void value_error(input string name, input logic [255:0] exp_val,
                                        input logic [255:0] act_val);
        error_count++;
        $display("ERROR at %0t: %s expected %0h, got %0h", $time, name, exp_val, act_val);
    endfunction

    function automatic void event_error(input string what);
        error_count++;
        $display("error at %0t: %s", $time, what);
    endfunction

    // beat position, completion counts and the reference memory
    always @(posedge clock or negedge reset) begin : monitor
        int base;
        if (!reset) begin
            beat_idx       <= '0;
            rd_done_cnt    <= 0;
            fetch_done_cnt <= 0;
            wr_done_cnt    <= 0;
        end else begin
            if (dc_rd_beat_valid) begin
                beat_idx <= dc_rd_last ? 2'd0 : beat_idx + 2'd1;
                if (dc_rd_last) rd_done_cnt <= rd_done_cnt + 1;
            end
            if (ic_line_valid) fetch_done_cnt <= fetch_done_cnt + 1;
            if (dc_wr_done) begin
                base = line_base(wr_cur_addr);
                for (int b = 0; b < 32; b++)
                    if (wr_cur_mask[b]) ref_mem[base + b/8][(b%8)*8 +: 8] = wr_cur_line[b*8 +: 8];
                wr_done_cnt <= wr_done_cnt + 1;
            end
        end
    end

    always @(posedge clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    assign exp_dc_beat = exp_dc_line[beat_idx*64 +: 64];

    reset_outputs: assert property (@(posedge clock) !reset |->
        {dc_rd_beat_valid, ic_line_valid, dc_wr_done,
         dc_rd_req_ready, dc_wr_req_ready, ic_fetch_ready} == 6'b000111)
        else value_error("reset outputs", 256'(6'b000111),
                         256'($sampled({dc_rd_beat_valid, ic_line_valid, dc_wr_done,
                                        dc_rd_req_ready, dc_wr_req_ready, ic_fetch_ready})));
    dc_beat_data: assert property (@(posedge clock) disable iff (!reset)
        dc_rd_beat_valid |-> dc_rd_beat == exp_dc_beat)
        else value_error("dc_rd_beat", 256'($sampled(exp_dc_beat)), 256'($sampled(dc_rd_beat)));
    dc_beat_last: assert property (@(posedge clock) disable iff (!reset)
        dc_rd_beat_valid |-> dc_rd_last == (beat_idx == 2'd3))
        else value_error("dc_rd_last", 256'($sampled(beat_idx == 2'd3)),
                         256'($sampled(dc_rd_last)));
    dc_beat_owned: assert property (@(posedge clock) disable iff (!reset)
        dc_rd_beat_valid |-> rd_issued != rd_done_cnt)
        else event_error("data read beat arrived with no data read pending");
    ic_line_data: assert property (@(posedge clock) disable iff (!reset)
        ic_line_valid |-> ic_line == exp_ic_line)
        else value_error("ic_line", $sampled(exp_ic_line), $sampled(ic_line));
    ic_line_owned: assert property (@(posedge clock) disable iff (!reset)
        ic_line_valid |-> fetch_issued != fetch_done_cnt)
        else event_error("instruction line arrived with no fetch pending");
    wr_done_owned: assert property (@(posedge clock) disable iff (!reset)
        dc_wr_done |-> wr_issued != wr_done_cnt)
        else event_error("write done pulsed with no write pending");

    task automatic tick;
        @(posedge clock);
        #1;
    endtask

    task automatic write_line(input cache_axi_pkg::addr_t addr, input cache_axi_pkg::line_t line,
                              input cache_axi_pkg::line_mask_t mask);
        int start;
        start = wr_done_cnt;
        while (!dc_wr_req_ready) tick();
        wr_cur_addr = addr;
        wr_cur_line = line;
        wr_cur_mask = mask;
        dc_wr_req_valid = 1'b1;
        dc_wr_addr = addr;
        dc_wr_line = line;
        dc_wr_mask = mask;
        wr_issued++;
        tick();    // accepted on this edge
        dc_wr_req_valid = 1'b0;
        while (wr_done_cnt == start) tick();
    endtask

    task automatic start_read(input cache_axi_pkg::addr_t addr, input cache_axi_pkg::line_t exp_line);
        while (!dc_rd_req_ready) tick();
        exp_dc_line = exp_line;
        dc_rd_req_valid = 1'b1;
        dc_rd_addr = addr;
        rd_issued++;
    endtask

    task automatic start_fetch(input cache_axi_pkg::addr_t addr, input cache_axi_pkg::line_t exp_line);
        while (!ic_fetch_ready) tick();
        exp_ic_line = exp_line;
        ic_fetch_valid = 1'b1;
        ic_fetch_addr = addr;
        fetch_issued++;
    endtask

    // drop the requests and wait for every read and fetch to finish
    task automatic settle_reads;
        tick();
        dc_rd_req_valid = 1'b0;
        ic_fetch_valid = 1'b0;
        while (rd_done_cnt != rd_issued || fetch_done_cnt != fetch_issued) tick();
    endtask

    task automatic end_test(input string name);
        if (error_count == test_errors) begin
            pass_count++;
            $display("test %s: passed", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    initial begin
        cache_axi_pkg::addr_t a_addr;
        cache_axi_pkg::addr_t b_addr;
        cache_axi_pkg::addr_t addr;
        cache_axi_pkg::line_t a_line;
        cache_axi_pkg::line_t b_line;
        cache_axi_pkg::line_mask_t mask;
        logic [1:0] op;
        clock = 1'b0;
        reset = 1'b1;
        dc_rd_req_valid = 1'b0;
        dc_rd_addr = '0;
        dc_wr_req_valid = 1'b0;
        dc_wr_addr = '0;
        dc_wr_line = '0;
        dc_wr_mask = '0;
        ic_fetch_valid = 1'b0;
        ic_fetch_addr = '0;
        exp_dc_line = '0;
        exp_ic_line = '0;
        wr_cur_addr = '0;
        wr_cur_line = '0;
        wr_cur_mask = '0;
        lfsr = 16'd2748;
        rd_issued = 0;
        fetch_issued = 0;
        wr_issued = 0;
        cycle_cnt = 0;
        error_count = 0;
        test_errors = 0;
        pass_count = 0;
        fail_count = 0;
        #1 reset = 1'b0;    // clean falling edge
        repeat (8) @(posedge clock);
        #1 reset = 1'b1;
        after_reset: assert ({dc_rd_beat_valid, ic_line_valid, dc_wr_done,
                              dc_rd_req_ready, dc_wr_req_ready, ic_fetch_ready} == 6'b000111)
            else value_error("outputs after reset", 256'(6'b000111),
                             256'({dc_rd_beat_valid, ic_line_valid, dc_wr_done,
                                   dc_rd_req_ready, dc_wr_req_ready, ic_fetch_ready}));
        end_test("reset_state");

        // sram is not reset, so give every line a known value first
        for (int w = 0; w < LINES; w++) begin
            for (int k = 0; k < cache_axi_pkg::BEATS_PER_LINE; k++)
                a_line[k*64 +: 64] = fill_beat(w * cache_axi_pkg::BEATS_PER_LINE + k);
            write_line(cache_axi_pkg::addr_t'(w * 32), a_line, '1);
        end

        a_addr = cache_axi_pkg::addr_t'(take_bits(32));
        a_line = cache_axi_pkg::line_t'(take_bits(256));
        write_line(a_addr, a_line, '1);
        start_read(a_addr, a_line);
        settle_reads();
        end_test("full_write_read");

        b_line = cache_axi_pkg::line_t'(take_bits(256));
        mask = cache_axi_pkg::line_mask_t'(take_bits(32));
        write_line(a_addr, b_line, mask);
        start_read(a_addr, merge_line(a_line, b_line, mask));
        settle_reads();
        end_test("masked_write_read");

        start_fetch(a_addr, ref_line(a_addr));
        settle_reads();
        end_test("instr_fetch");

        b_addr = a_addr ^ 32'h20;    // neighbour line, still preload content
        for (int i = 0; i < 2; i++) begin
            start_fetch(i == 0 ? a_addr : b_addr, ref_line(i == 0 ? a_addr : b_addr));
            start_read(i == 0 ? b_addr : a_addr, ref_line(i == 0 ? b_addr : a_addr));
            settle_reads();
        end
        end_test("same_cycle_reads");

        for (int i = 0; i < RAND_OPS; i++) begin
            op = 2'(take_bits(2));
            addr = cache_axi_pkg::addr_t'(take_bits(32));
            case (op)
                2'd0, 2'd1: begin
                    a_line = cache_axi_pkg::line_t'(take_bits(256));
                    mask = cache_axi_pkg::line_mask_t'(take_bits(32));
                    write_line(addr, a_line, mask);
                end
                2'd2: begin
                    start_read(addr, ref_line(addr));
                    settle_reads();
                end
                default: begin
                    start_fetch(addr, ref_line(addr));
                    settle_reads();
                end
            endcase
        end
        end_test("random_ops");

        $display("tests: %0d passed, %0d failed, %0d errors", pass_count, fail_count, error_count);
        if (error_count == 0 && fail_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
